// File: verilog/rob_pkg.sv
package rob_pkg;

    localparam int xlen      = 32;
    localparam int reg_w     = 5;
    localparam int rob_depth = 8;
    localparam int tag_w     = 3;
    localparam int op_w      = 3;

    // internal op codes seen by the execute units
    localparam logic [op_w-1:0] op_add = 3'd0;
    localparam logic [op_w-1:0] op_sub = 3'd1;
    localparam logic [op_w-1:0] op_and = 3'd2;
    localparam logic [op_w-1:0] op_or  = 3'd3;
    localparam logic [op_w-1:0] op_xor = 3'd4;
    localparam logic [op_w-1:0] op_mul = 3'd5;
    localparam logic [op_w-1:0] op_beq = 3'd6;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_opimm  = 7'b0010011;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [6:0]       funct7;
            logic [reg_w-1:0] rs2;
            logic [reg_w-1:0] rs1;
            logic [2:0]       funct3;
            logic [reg_w-1:0] rd;
            logic [6:0]       opcode;
        } r_fmt;
        struct packed {
            logic [11:0]      imm12;
            logic [reg_w-1:0] rs1;
            logic [2:0]       funct3;
            logic [reg_w-1:0] rd;
            logic [6:0]       opcode;
        } i_fmt;
        struct packed {
            logic             imm_12;
            logic [5:0]       imm_10_5;
            logic [reg_w-1:0] rs2;
            logic [reg_w-1:0] rs1;
            logic [2:0]       funct3;
            logic [3:0]       imm_4_1;
            logic             imm_11;
            logic [6:0]       opcode;
        } b_fmt;
    } inst_word_u;

endpackage

// File: verilog/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        inst_valid,
    output logic                        inst_ready,
    input  logic [31:0]                 inst_word,
    input  logic [rob_pkg::xlen-1:0]    inst_pc,
    output logic [rob_pkg::reg_w-1:0]   rs1_addr,
    output logic [rob_pkg::reg_w-1:0]   rs2_addr,
    input  logic [rob_pkg::xlen-1:0]    rs1_data,
    input  logic [rob_pkg::xlen-1:0]    rs2_data,
    input  logic                        rs1_pending,
    input  logic                        rs2_pending,
    input  logic                        rob_full,
    input  logic [rob_pkg::tag_w-1:0]   rob_free_tag,
    input  logic                        flush,
    output logic                        rob_alloc,
    output logic [rob_pkg::reg_w-1:0]   rob_alloc_rd,
    output logic                        rob_alloc_branch,
    output logic [rob_pkg::xlen-1:0]    rob_alloc_target,
    output logic                        alu_issue,
    output logic                        mul_issue,
    output logic [rob_pkg::op_w-1:0]    issue_op,
    output logic [rob_pkg::tag_w-1:0]   issue_tag,
    output logic [rob_pkg::xlen-1:0]    issue_opa,
    output logic [rob_pkg::xlen-1:0]    issue_opb
);

    rob_pkg::inst_word_u iw;
    logic [rob_pkg::op_w-1:0]  op;
    logic [rob_pkg::reg_w-1:0] rd;
    logic                      use_rs1;
    logic                      use_rs2;
    logic                      is_imm;
    logic                      is_branch;
    logic                      is_mul;
    logic [rob_pkg::xlen-1:0]  imm_i;
    logic [rob_pkg::xlen-1:0]  imm_b;
    logic                      hazard;
    logic                      accept;

    assign iw       = inst_word;
    assign rs1_addr = iw.r_fmt.rs1;
    assign rs2_addr = iw.r_fmt.rs2;

    assign imm_i = {{(rob_pkg::xlen-12){iw.i_fmt.imm12[11]}}, iw.i_fmt.imm12};
    assign imm_b = {{(rob_pkg::xlen-12){iw.b_fmt.imm_12}}, iw.b_fmt.imm_11,
                    iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};

    // unknown words fall through as add to x0 with no sources
    always_comb begin
        op        = rob_pkg::op_add;
        rd        = '0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        is_imm    = 1'b0;
        is_branch = 1'b0;
        case (iw.r_fmt.opcode)
            rob_pkg::opc_op: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                rd      = iw.r_fmt.rd;
                case ({iw.r_fmt.funct7, iw.r_fmt.funct3})
                    {7'h00, 3'h0}: op = rob_pkg::op_add;
                    {7'h20, 3'h0}: op = rob_pkg::op_sub;
                    {7'h00, 3'h7}: op = rob_pkg::op_and;
                    {7'h00, 3'h6}: op = rob_pkg::op_or;
                    {7'h00, 3'h4}: op = rob_pkg::op_xor;
                    {7'h01, 3'h0}: op = rob_pkg::op_mul;
                    default: begin
                        rd      = '0;
                        use_rs1 = 1'b0;
                        use_rs2 = 1'b0;
                    end
                endcase
            end
            rob_pkg::opc_opimm: begin
                if (iw.i_fmt.funct3 == 3'h0) begin   // addi only
                    use_rs1 = 1'b1;
                    is_imm  = 1'b1;
                    rd      = iw.i_fmt.rd;
                end
            end
            rob_pkg::opc_branch: begin
                if (iw.b_fmt.funct3 == 3'h0) begin   // beq only
                    op        = rob_pkg::op_beq;
                    use_rs1   = 1'b1;
                    use_rs2   = 1'b1;
                    is_branch = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign is_mul = (op == rob_pkg::op_mul);
    assign hazard = (use_rs1 && rs1_pending) || (use_rs2 && rs2_pending);

    assign inst_ready = !rst && !flush && !rob_full && !hazard;
    assign accept     = inst_valid && inst_ready;

    assign rob_alloc        = accept;
    assign rob_alloc_rd     = rd;
    assign rob_alloc_branch = is_branch;
    assign rob_alloc_target = inst_pc + imm_b;

    assign alu_issue = accept && !is_mul;
    assign mul_issue = accept && is_mul;
    assign issue_op  = op;
    assign issue_tag = rob_free_tag;
    assign issue_opa = rs1_data;
    assign issue_opb = is_imm ? imm_i : rs2_data;

endmodule

// File: verilog/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        alu_issue,
    input  logic [rob_pkg::op_w-1:0]    issue_op,
    input  logic [rob_pkg::tag_w-1:0]   issue_tag,
    input  logic [rob_pkg::xlen-1:0]    issue_opa,
    input  logic [rob_pkg::xlen-1:0]    issue_opb,
    output logic                        alu_wb_valid,
    output logic [rob_pkg::tag_w-1:0]   alu_wb_tag,
    output logic [rob_pkg::xlen-1:0]    alu_wb_data,
    output logic                        alu_wb_taken
);

    logic [rob_pkg::xlen-1:0] result;

    always_comb begin
        case (issue_op)
            rob_pkg::op_sub: result = issue_opa - issue_opb;
            rob_pkg::op_and: result = issue_opa & issue_opb;
            rob_pkg::op_or:  result = issue_opa | issue_opb;
            rob_pkg::op_xor: result = issue_opa ^ issue_opb;
            rob_pkg::op_beq: result = '0;   // branch writes nothing
            default:         result = issue_opa + issue_opb;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush)
            alu_wb_valid <= 1'b0;
        else
            alu_wb_valid <= alu_issue;
    end

    always_ff @(posedge clk) begin
        alu_wb_tag   <= issue_tag;
        alu_wb_data  <= result;
        alu_wb_taken <= (issue_op == rob_pkg::op_beq) && (issue_opa == issue_opb);
    end

endmodule

// File: verilog/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        mul_issue,
    input  logic [rob_pkg::tag_w-1:0]   issue_tag,
    input  logic [rob_pkg::xlen-1:0]    issue_opa,
    input  logic [rob_pkg::xlen-1:0]    issue_opb,
    output logic                        mul_wb_valid,
    output logic [rob_pkg::tag_w-1:0]   mul_wb_tag,
    output logic [rob_pkg::xlen-1:0]    mul_wb_data
);

    logic                       s1_valid;
    logic                       s2_valid;
    logic [rob_pkg::tag_w-1:0]  s1_tag;
    logic [rob_pkg::tag_w-1:0]  s2_tag;
    logic [rob_pkg::xlen-1:0]   s1_a;
    logic [rob_pkg::xlen-1:0]   s1_b;
    logic [rob_pkg::xlen-1:0]   s2_prod;

    // one product may enter per cycle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            mul_wb_valid <= 1'b0;
        end else begin
            s1_valid     <= mul_issue;
            s2_valid     <= s1_valid;
            mul_wb_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_a        <= issue_opa;   // operand capture
        s1_b        <= issue_opb;
        s1_tag      <= issue_tag;
        s2_prod     <= s1_a * s1_b; // low word only
        s2_tag      <= s1_tag;
        mul_wb_data <= s2_prod;
        mul_wb_tag  <= s2_tag;
    end

endmodule

// File: verilog/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rob_alloc,
    input  logic [rob_pkg::reg_w-1:0]   rob_alloc_rd,
    input  logic                        rob_alloc_branch,
    input  logic [rob_pkg::xlen-1:0]    rob_alloc_target,
    output logic                        rob_full,
    output logic [rob_pkg::tag_w-1:0]   rob_free_tag,
    input  logic                        alu_wb_valid,
    input  logic [rob_pkg::tag_w-1:0]   alu_wb_tag,
    input  logic [rob_pkg::xlen-1:0]    alu_wb_data,
    input  logic                        alu_wb_taken,
    input  logic                        mul_wb_valid,
    input  logic [rob_pkg::tag_w-1:0]   mul_wb_tag,
    input  logic [rob_pkg::xlen-1:0]    mul_wb_data,
    output logic                        commit_valid,
    output logic [rob_pkg::reg_w-1:0]   commit_rd,
    output logic [rob_pkg::xlen-1:0]    commit_data,
    output logic [rob_pkg::tag_w-1:0]   commit_tag,
    output logic                        redirect_valid,
    output logic [rob_pkg::xlen-1:0]    redirect_pc
);

    logic [rob_pkg::rob_depth-1:0] busy;
    logic [rob_pkg::rob_depth-1:0] done;
    logic [rob_pkg::rob_depth-1:0] is_br;
    logic [rob_pkg::rob_depth-1:0] taken;
    logic [rob_pkg::reg_w-1:0]     rd_q     [rob_pkg::rob_depth];
    logic [rob_pkg::xlen-1:0]      data_q   [rob_pkg::rob_depth];
    logic [rob_pkg::xlen-1:0]      target_q [rob_pkg::rob_depth];

    logic [rob_pkg::tag_w-1:0] head;
    logic [rob_pkg::tag_w-1:0] tail;
    logic [rob_pkg::tag_w:0]   count;
    logic                      head_done;
    logic                      head_redirect;

    assign head_done     = busy[head] && done[head];
    assign head_redirect = head_done && is_br[head] && taken[head];

    assign rob_full     = (count == (rob_pkg::tag_w + 1)'(rob_pkg::rob_depth));
    assign rob_free_tag = tail;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy           <= '0;
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            commit_valid   <= 1'b0;
            redirect_valid <= 1'b0;
        end else if (head_redirect) begin
            // mispredict, drop every entry including any allocated now
            busy           <= '0;
            head           <= head + 1'b1;
            tail           <= head + 1'b1;
            count          <= '0;
            commit_valid   <= 1'b0;
            redirect_valid <= 1'b1;
        end else begin
            commit_valid   <= head_done && !is_br[head];   // branch retires silently
            redirect_valid <= 1'b0;
            if (head_done) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            if (rob_alloc) begin
                busy[tail] <= 1'b1;
                tail       <= tail + 1'b1;
            end
            case ({rob_alloc, head_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry payload and writeback
    always_ff @(posedge clk) begin
        if (rob_alloc) begin
            rd_q[tail]     <= rob_alloc_rd;
            is_br[tail]    <= rob_alloc_branch;
            target_q[tail] <= rob_alloc_target;
            done[tail]     <= 1'b0;
            taken[tail]    <= 1'b0;
        end
        // stale results after a flush land on free entries and are dropped
        if (alu_wb_valid && busy[alu_wb_tag]) begin
            data_q[alu_wb_tag] <= alu_wb_data;
            taken[alu_wb_tag]  <= alu_wb_taken;
            done[alu_wb_tag]   <= 1'b1;
        end
        if (mul_wb_valid && busy[mul_wb_tag]) begin
            data_q[mul_wb_tag] <= mul_wb_data;
            done[mul_wb_tag]   <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        commit_rd   <= rd_q[head];
        commit_data <= data_q[head];
        commit_tag  <= head;
        redirect_pc <= target_q[head];
    end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [rob_pkg::reg_w-1:0]   rs1_addr,
    input  logic [rob_pkg::reg_w-1:0]   rs2_addr,
    output logic [rob_pkg::xlen-1:0]    rs1_data,
    output logic [rob_pkg::xlen-1:0]    rs2_data,
    output logic                        rs1_pending,
    output logic                        rs2_pending,
    input  logic                        alloc_en,
    input  logic [rob_pkg::reg_w-1:0]   alloc_rd,
    input  logic [rob_pkg::tag_w-1:0]   alloc_tag,
    input  logic                        commit_valid,
    input  logic [rob_pkg::reg_w-1:0]   commit_rd,
    input  logic [rob_pkg::xlen-1:0]    commit_data,
    input  logic [rob_pkg::tag_w-1:0]   commit_tag,
    input  logic                        flush
);

    logic [rob_pkg::xlen-1:0]      regs [2**rob_pkg::reg_w];
    logic [rob_pkg::tag_w-1:0]     ptag [2**rob_pkg::reg_w];
    logic [2**rob_pkg::reg_w-1:0]  pending;

    assign rs1_data    = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data    = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign rs1_pending = pending[rs1_addr];   // x0 never set
    assign rs2_pending = pending[rs2_addr];

    always_ff @(posedge clk) begin
        if (commit_valid && commit_rd != '0)
            regs[commit_rd] <= commit_data;
        if (alloc_en && alloc_rd != '0)
            ptag[alloc_rd] <= alloc_tag;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            pending <= '0;
        end else begin
            // only the newest writer's commit releases the register
            if (commit_valid && commit_rd != '0 && ptag[commit_rd] == commit_tag)
                pending[commit_rd] <= 1'b0;
            if (alloc_en && alloc_rd != '0)
                pending[alloc_rd] <= 1'b1;   // wins over a same-cycle commit
        end
    end

endmodule

// File: verilog/ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        inst_valid,
    output logic                        inst_ready,
    input  logic [31:0]                 inst_word,
    input  logic [rob_pkg::xlen-1:0]    inst_pc,
    output logic                        commit_valid,
    output logic [rob_pkg::reg_w-1:0]   commit_rd,
    output logic [rob_pkg::xlen-1:0]    commit_data,
    output logic [rob_pkg::tag_w-1:0]   commit_tag,
    output logic                        redirect_valid,
    output logic [rob_pkg::xlen-1:0]    redirect_pc
);

    logic [rob_pkg::reg_w-1:0] rs1_addr;
    logic [rob_pkg::reg_w-1:0] rs2_addr;
    logic [rob_pkg::xlen-1:0]  rs1_data;
    logic [rob_pkg::xlen-1:0]  rs2_data;
    logic                      rs1_pending;
    logic                      rs2_pending;
    logic                      rob_full;
    logic [rob_pkg::tag_w-1:0] rob_free_tag;
    logic                      rob_alloc;
    logic [rob_pkg::reg_w-1:0] rob_alloc_rd;
    logic                      rob_alloc_branch;
    logic [rob_pkg::xlen-1:0]  rob_alloc_target;
    logic                      alu_issue;
    logic                      mul_issue;
    logic [rob_pkg::op_w-1:0]  issue_op;
    logic [rob_pkg::tag_w-1:0] issue_tag;
    logic [rob_pkg::xlen-1:0]  issue_opa;
    logic [rob_pkg::xlen-1:0]  issue_opb;
    logic                      alu_wb_valid;
    logic [rob_pkg::tag_w-1:0] alu_wb_tag;
    logic [rob_pkg::xlen-1:0]  alu_wb_data;
    logic                      alu_wb_taken;
    logic                      mul_wb_valid;
    logic [rob_pkg::tag_w-1:0] mul_wb_tag;
    logic [rob_pkg::xlen-1:0]  mul_wb_data;

    // redirect doubles as the flush
    inst_decode u_decode (.*, .flush(redirect_valid));

    alu_unit u_alu (.*, .flush(redirect_valid));

    mul_unit u_mul (.*, .flush(redirect_valid));

    reorder_buffer u_rob (.*);

    reg_file u_rf (
        .*,
        .alloc_en  (rob_alloc),
        .alloc_rd  (rob_alloc_rd),
        .alloc_tag (rob_free_tag),
        .flush     (redirect_valid)
    );

endmodule

// File: dv/ooo_core_asserts.sv
`timescale 1ns/1ps

module ooo_core_asserts (
    input logic        clk,
    input logic        rst,
    input logic        inst_valid,
    input logic        inst_ready,
    input logic [31:0] inst_word,
    input logic        commit_valid,
    input logic        redirect_valid
);

    a_excl: assert property (@(posedge clk) !(commit_valid && redirect_valid))
        else $error("commit and redirect in the same cycle");

    a_reset: assert property (@(posedge clk) rst |=> !commit_valid && !redirect_valid)
        else $error("retire activity during reset");

    a_hold: assert property (@(posedge clk) disable iff (rst)
        inst_valid && !inst_ready |=> $stable(inst_word))
        else $error("inst_word changed while stalled");

    a_pulse: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |=> !redirect_valid)   // single cycle redirect
        else $error("redirect_valid held for more than one cycle");

endmodule

bind ooo_core_top ooo_core_asserts u_asserts (.*);

// File: dv/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb;

    localparam logic [2:0] k_add  = 3'd0;
    localparam logic [2:0] k_sub  = 3'd1;
    localparam logic [2:0] k_and  = 3'd2;
    localparam logic [2:0] k_or   = 3'd3;
    localparam logic [2:0] k_xor  = 3'd4;
    localparam logic [2:0] k_mul  = 3'd5;
    localparam logic [2:0] k_addi = 3'd6;
    localparam logic [2:0] k_beq  = 3'd7;

    typedef struct packed {
        logic [2:0]                   kind;
        logic [rob_pkg::reg_w-1:0]    rd;
        logic [rob_pkg::reg_w-1:0]    rs1;
        logic [rob_pkg::reg_w-1:0]    rs2;
        logic [rob_pkg::xlen-1:0]     imm;
        logic [rob_pkg::xlen-1:0]     pc;
        logic [rob_pkg::tag_w-1:0]    tag;
    } ent_t;

    logic                          clk;
    logic                          rst;
    logic                          inst_valid;
    logic                          inst_ready;
    logic [31:0]                   inst_word;
    logic [rob_pkg::xlen-1:0]      inst_pc;
    logic                          commit_valid;
    logic [rob_pkg::reg_w-1:0]     commit_rd;
    logic [rob_pkg::xlen-1:0]      commit_data;
    logic [rob_pkg::tag_w-1:0]     commit_tag;
    logic                          redirect_valid;
    logic [rob_pkg::xlen-1:0]      redirect_pc;

    logic [31:0]                   lfsr = 32'hdeb4e2ed;
    logic [rob_pkg::xlen-1:0]      arch [8];
    ent_t                          q [$];
    ent_t                          pend_e;
    ent_t                          acc_e;
    logic [rob_pkg::tag_w-1:0]     next_tag;
    logic [rob_pkg::xlen-1:0]      pc_next;
    string                         cur_test;
    int                            errors;
    int                            commits;
    int                            redirects;
    int                            stalls;
    int                            tests;
    int                            failed;
    int                            err0;
    int                            com0;

    ooo_core_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check_data(input string what, input logic [rob_pkg::xlen-1:0] exp,
                              input logic [rob_pkg::xlen-1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_reg(input string what, input logic [rob_pkg::reg_w-1:0] exp,
                             input logic [rob_pkg::reg_w-1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected x%0d, actual x%0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_tag(input string what, input logic [rob_pkg::tag_w-1:0] exp,
                             input logic [rob_pkg::tag_w-1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic fail_msg(input string msg);
        $display("ERROR %s: %s", cur_test, msg);
        errors++;
    endtask

    // reference semantics of the subset
    task automatic execute(input ent_t e, output logic tk, output logic [rob_pkg::xlen-1:0] v);
        logic [rob_pkg::xlen-1:0] a;
        logic [rob_pkg::xlen-1:0] b;
        a  = arch[e.rs1[2:0]];
        b  = arch[e.rs2[2:0]];
        tk = 1'b0;
        case (e.kind)
            k_sub:   v = a - b;
            k_and:   v = a & b;
            k_or:    v = a | b;
            k_xor:   v = a ^ b;
            k_mul:   v = a * b;
            k_addi:  v = a + e.imm;
            k_beq: begin
                v  = '0;
                tk = (a == b);
            end
            default: v = a + b;
        endcase
    endtask

    // not-taken branches retire without any commit strobe
    task automatic skip_branches();
        logic                     tk;
        logic [rob_pkg::xlen-1:0] v;
        while (q.size() > 0 && q[0].kind == k_beq) begin
            execute(q[0], tk, v);
            if (tk)
                return;
            void'(q.pop_front());
        end
    endtask

    task automatic retire_commit();
        ent_t                     e;
        logic                     tk;
        logic [rob_pkg::xlen-1:0] v;
        skip_branches();
        if (q.size() == 0) begin
            fail_msg("commit seen with no instruction outstanding");
            return;
        end
        e = q.pop_front();
        if (e.kind == k_beq)
            fail_msg("taken branch retired without a redirect");
        execute(e, tk, v);
        check_tag("commit_tag", e.tag, commit_tag);
        check_reg("commit_rd", e.rd, commit_rd);
        if (e.rd != '0) begin
            check_data("commit_data", v, commit_data);
            arch[e.rd[2:0]] = v;
        end
        commits++;
    endtask

    task automatic retire_redirect();
        ent_t e;
        skip_branches();
        if (q.size() == 0 || q[0].kind != k_beq) begin
            fail_msg("redirect without a taken branch at the head");
            q.delete();
            return;
        end
        e = q.pop_front();
        check_data("redirect_pc", e.pc + e.imm, redirect_pc);
        next_tag = e.tag + 1'b1;   // tags restart behind the branch
        q.delete();
        redirects++;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (inst_valid && inst_ready) begin
                acc_e     = pend_e;
                acc_e.tag = next_tag;
                q.push_back(acc_e);
                next_tag  = next_tag + 1'b1;
            end
            if (inst_valid && !inst_ready)
                stalls++;
            if (commit_valid)
                retire_commit();
            if (redirect_valid)
                retire_redirect();
        end
    end

    function automatic logic [31:0] encode(input ent_t e);
        logic [12:0] bi;
        bi = e.imm[12:0];
        case (e.kind)
            k_sub:  return {7'h20, e.rs2, e.rs1, 3'h0, e.rd, 7'b0110011};
            k_and:  return {7'h00, e.rs2, e.rs1, 3'h7, e.rd, 7'b0110011};
            k_or:   return {7'h00, e.rs2, e.rs1, 3'h6, e.rd, 7'b0110011};
            k_xor:  return {7'h00, e.rs2, e.rs1, 3'h4, e.rd, 7'b0110011};
            k_mul:  return {7'h01, e.rs2, e.rs1, 3'h0, e.rd, 7'b0110011};
            k_addi: return {e.imm[11:0], e.rs1, 3'h0, e.rd, 7'b0010011};
            k_beq:  return {bi[12], bi[10:5], e.rs2, e.rs1, 3'h0, bi[4:1], bi[11],
                            7'b1100011};
            default: return {7'h00, e.rs2, e.rs1, 3'h0, e.rd, 7'b0110011};
        endcase
    endfunction

    task automatic send(input logic [2:0] kind, input int rd, input int rs1, input int rs2,
                        input logic [31:0] imm);
        ent_t e;
        int   cnt;
        e = '{kind: kind, rd: rd[4:0], rs1: rs1[4:0], rs2: rs2[4:0], imm: imm,
              pc: pc_next, tag: '0};
        if (kind == k_beq)
            e.rd = '0;
        inst_valid <= 1'b1;
        inst_word  <= encode(e);
        inst_pc    <= pc_next;
        pend_e     <= e;
        pc_next     = pc_next + 32'd4;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (!inst_ready && cnt < 200);
        if (!inst_ready) begin
            fail_msg("inst_ready stuck low for 200 cycles");
            inst_valid <= 1'b0;
        end
    endtask

    task automatic idle(input int n);
        inst_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic send_random(input logic [2:0] kind);
        logic [31:0] imm;
        logic [11:0] r12;
        r12 = 12'(rnd(12));
        if (kind == k_beq)
            imm = {{19{r12[11]}}, r12, 1'b0};   // even branch offset
        else
            imm = {{20{r12[11]}}, r12};
        send(kind, int'(rnd(3)), int'(rnd(3)), int'(rnd(3)), imm);
        if (rnd(2) == 0)
            idle(1);
    endtask

    task automatic drain();
        int cnt;
        send(k_addi, 0, 0, 0, 32'd0);   // trailing nop retires any silent branch
        idle(1);
        cnt = 0;
        while (q.size() > 0 && cnt < 2000) begin
            @(posedge clk);
            cnt++;
        end
        if (q.size() > 0) begin
            fail_msg($sformatf("%0d instructions never retired", q.size()));
            q.delete();
        end
        idle(4);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err0     = errors;
        com0     = commits;
    endtask

    task automatic report_test();
        tests++;
        if (errors > err0)
            failed++;
        $display("%s: %s, %0d commits, %0d errors", cur_test,
                 (errors > err0) ? "FAILED" : "ok", commits - com0, errors - err0);
    endtask

    task automatic end_test();
        drain();
        report_test();
    endtask

    initial begin
        int          r0;
        int          s0;
        logic [11:0] v12;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst_word  = '0;
        inst_pc    = '0;
        pend_e     = '0;
        pc_next    = 32'h1000;
        next_tag   = '0;
        errors     = 0;
        commits    = 0;
        redirects  = 0;
        stalls     = 0;
        tests      = 0;
        failed     = 0;
        for (int i = 0; i < 8; i++)
            arch[i] = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        start_test("alu_ops");
        for (int i = 1; i < 8; i++) begin
            v12 = 12'(rnd(12));
            send(k_addi, i, 0, 0, {{20{v12[11]}}, v12});
        end
        for (int i = 0; i < 200; i++)
            send_random((rnd(3) >= 5) ? k_addi : 3'(rnd(3) % 5));
        end_test();

        start_test("mul_reorder");
        for (int i = 0; i < 4; i++) begin
            send(k_mul, 1 + i, 6, 7, 0);
            send(k_add, 5, 6, 7, 0);
            send(k_xor, 0, 6, 7, 0);
            send(k_addi, 6 - i % 2, 7, 0, 32'd5);
        end
        end_test();

        start_test("hazard_stall");
        s0 = stalls;
        send(k_mul, 1, 2, 3, 0);
        send(k_add, 4, 1, 2, 0);
        send(k_mul, 5, 4, 4, 0);
        send(k_sub, 6, 5, 1, 0);
        send(k_addi, 7, 6, 0, 32'd3);
        send(k_and, 2, 7, 6, 0);
        send(k_mul, 3, 2, 7, 0);
        if (stalls == s0)
            fail_msg("inst_ready never dropped on a pending source");
        end_test();

        start_test("rob_full");
        s0 = commits;
        for (int i = 0; i < 16; i++) begin
            if (i % 2 == 0)
                send(k_mul, 1 + i % 5, 6, 7, 0);
            else
                send(k_add, 1 + i % 5, 7, 6, 0);
        end
        drain();
        if (commits - s0 != 17)
            fail_msg($sformatf("burst of 17 gave %0d commits", commits - s0));
        report_test();

        start_test("branch_flush");
        r0 = redirects;
        send(k_addi, 1, 0, 0, 32'd5);
        send(k_addi, 2, 0, 0, 32'd9);
        send(k_beq, 0, 1, 1, 32'd64);   // taken so younger ones must vanish
        send(k_add, 3, 1, 2, 0);
        send(k_mul, 4, 2, 2, 0);
        send(k_sub, 5, 2, 1, 0);
        idle(6);
        send(k_beq, 0, 1, 2, 32'hfffffff0);
        send(k_add, 3, 1, 2, 0);
        drain();
        if (redirects - r0 != 1)
            fail_msg($sformatf("expected one redirect, saw %0d", redirects - r0));
        report_test();

        start_test("random_mix");
        for (int i = 0; i < 2000; i++)
            send_random(3'(rnd(3)));
        end_test();

        $display("%0d tests, %0d failed, %0d errors, %0d commits, %0d redirects",
                 tests, failed, errors, commits, redirects);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: vlog.f
verilog/rob_pkg.sv
verilog/inst_decode.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/reorder_buffer.sv
verilog/reg_file.sv
verilog/ooo_core_top.sv
dv/ooo_core_asserts.sv
dv/ooo_core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module ooo_core_tb -o sim_ooo
out=$(./obj_dir/sim_ooo)
echo "$out"
if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi
